// ==== source/tetris_pkg.sv ====
package tetris_pkg;

	////////////////////////////////////////////////////////////
	// Basic types
	////////////////////////////////////////////////////////////

	typedef logic [5:0] tile_code_t;	// Glyph or color index
	typedef logic [3:0] bcd_digit_t;

	// Tile memory address, row above column
	typedef struct packed {
		logic [4:0] row;
		logic [5:0] col;
	} tile_addr_t;

	typedef enum logic [2:0] {
		ST_START,
		ST_PLAYING,
		ST_PAUSE,
		ST_GAME_OVER,
		ST_NEW_GAME
	} game_state_e;

	////////////////////////////////////////////////////////////
	// Bundles between the blocks
	////////////////////////////////////////////////////////////

	typedef struct packed {
		game_state_e state;
		logic        frame_start;	// One cycle per frame
		logic        gravity_tick;	// Same cycle as frame_start
	} game_ctrl_t;

	typedef struct packed {
		bcd_digit_t [3:0] score_digits;	// [3] is thousands
		bcd_digit_t [3:0] line_digits;
		logic [4:0]       level;		// 1 .. 16
		logic             digits_valid;	// Low while converting
		logic [1:0]       spare;
	} score_disp_t;

	typedef struct packed {
		logic       en;
		tile_addr_t addr;
		tile_code_t data;
	} tile_wr_t;

	// Report from the playfield engine
	typedef struct packed {
		logic       valid;
		logic [2:0] count;	// Rows cleared, 0 .. 4
	} line_report_t;

	////////////////////////////////////////////////////////////
	// Game constants
	////////////////////////////////////////////////////////////

	localparam logic [7:0] KEY_PAUSE = 8'h50;	// 'P'
	localparam logic [7:0] KEY_NEW   = 8'h4E;	// 'N'

	localparam int VALUE_W = 14;	// Score and line counters
	localparam logic [4:0] GRAVITY_BASE = 5'd21;	// Frames per drop is this minus level
	localparam logic [4:0] LEVEL_MAX = 5'd16;
	localparam logic [VALUE_W-1:0] LINES_PER_LEVEL = 14'd8;
	localparam logic [VALUE_W-1:0] SCORE_MAX = 14'd9999;	// Fits four digits
	localparam logic [3:0] TETRIS_BONUS = 4'd8;	// Points for four rows at once

	localparam tile_code_t DIGIT_BASE = 6'd35;	// Glyph of '0'
	localparam tile_code_t BLANK_TILE = 6'd0;

	// Screen layout
	localparam logic [4:0] SCORE_ROW    = 5'd8;
	localparam logic [5:0] SCORE_COL    = 6'd27;
	localparam logic [4:0] LEVEL_ROW    = 5'd14;
	localparam logic [5:0] LEVEL_COL    = 6'd32;
	localparam logic [4:0] LINES_ROW    = 5'd8;
	localparam logic [5:0] LINES_COL    = 6'd3;
	localparam logic [4:0] GAMEOVER_ROW = 5'd5;
	localparam logic [5:0] GAMEOVER_COL = 6'd14;

	// Letters of GAMEOVER
	localparam tile_code_t GLYPH_G = 6'd49;
	localparam tile_code_t GLYPH_A = 6'd45;
	localparam tile_code_t GLYPH_M = 6'd52;
	localparam tile_code_t GLYPH_E = 6'd48;
	localparam tile_code_t GLYPH_O = 6'd54;
	localparam tile_code_t GLYPH_V = 6'd60;
	localparam tile_code_t GLYPH_R = 6'd56;

	// Tiles written per frame
	localparam logic [3:0] PLAY_WRITES = 4'd12;
	localparam logic [3:0] OVER_WRITES = 4'd8;

endpackage

// ==== source/bcd_convert.sv ====
module bcd_convert
	import tetris_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic [VALUE_W-1:0] value,
	output bcd_digit_t [3:0]   digits,
	output logic               busy
);

	logic [VALUE_W-1:0] bin_q;	// Binary bits still to shift in
	logic [15:0]        bcd_q;	// Partial BCD result
	logic [15:0]        adj;
	logic [15:0]        shifted;
	logic [3:0]         shift_cnt;

	// Add 3 to any digit of 5 or more before the shift
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (bcd_q[i*4 +: 4] >= 4'd5)
				adj[i*4 +: 4] = bcd_q[i*4 +: 4] + 4'd3;
			else
				adj[i*4 +: 4] = bcd_q[i*4 +: 4];
		end
	end

	assign shifted = {adj[14:0], bin_q[VALUE_W-1]};	// MSB first

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			bin_q <= value;	// Load cycle
			bcd_q <= '0;
		end
		else if (busy)
		begin
			bin_q <= bin_q << 1;
			bcd_q <= shifted;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			shift_cnt <= '0;
			digits    <= '0;	// Shows 0 straight out of reset
		end
		else if (start)
		begin
			busy      <= 1'b1;
			shift_cnt <= '0;
		end
		else if (busy)
		begin
			shift_cnt <= shift_cnt + 4'd1;
			if (shift_cnt == 4'(VALUE_W - 1))
			begin
				busy   <= 1'b0;
				digits <= shifted;	// Only whole results leave here
			end
		end
	end

endmodule

// ==== source/game_fsm.sv ====
module game_fsm
	import tetris_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en,
	input  logic       key_valid,
	input  logic [7:0] key_code,
	input  logic       top_out,
	input  logic [4:0] level,
	output game_ctrl_t ctrl
);

	logic        en_q;
	logic        en_qq;
	logic        en_rise;
	logic        frame_start;
	logic        gravity_tick;
	logic        pause_pend;	// Pause key waiting for a frame
	logic        new_pend;	// New-game key waiting for a frame
	logic        top_pend;	// Top-out waiting for a frame
	logic [4:0]  grav_cnt;
	logic [4:0]  grav_period;
	game_state_e state;

	assign en_rise     = en_q & ~en_qq;
	assign grav_period = GRAVITY_BASE - level;	// 20 frames at level 1, 5 at level 16

	////////////////////////////////////////////////////////////
	// Frame edge and gravity
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			en_q         <= 1'b0;
			en_qq        <= 1'b0;
			frame_start  <= 1'b0;
			gravity_tick <= 1'b0;
			grav_cnt     <= '0;
		end
		else
		begin
			en_q         <= en;
			en_qq        <= en_q;
			frame_start  <= en_rise;	// Lands one cycle after en is first seen
			gravity_tick <= 1'b0;
			if (state == ST_NEW_GAME)
				grav_cnt <= '0;	// Fresh piece timing
			else if (en_rise && state == ST_PLAYING)
			begin
				// >= covers a level-up that shortens the period
				if (grav_cnt + 5'd1 >= grav_period)
				begin
					gravity_tick <= 1'b1;
					grav_cnt     <= '0;
				end
				else
					grav_cnt <= grav_cnt + 5'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Event latches and game FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_START;
			pause_pend <= 1'b0;
			new_pend   <= 1'b0;
			top_pend   <= 1'b0;
		end
		else
		begin
			if (frame_start)
			begin
				case (state)
					ST_START:
					begin
						if (new_pend)
						begin
							state    <= ST_NEW_GAME;
							new_pend <= 1'b0;
						end
					end
					ST_NEW_GAME:
					begin
						state      <= ST_PLAYING;	// One frame only
						pause_pend <= 1'b0;	// Stale events from before
						top_pend   <= 1'b0;
					end
					ST_PLAYING:
					begin
						if (top_pend)	// Loss beats pause
						begin
							state      <= ST_GAME_OVER;
							top_pend   <= 1'b0;
							pause_pend <= 1'b0;
						end
						else if (pause_pend)
						begin
							state      <= ST_PAUSE;
							pause_pend <= 1'b0;
						end
					end
					ST_PAUSE:
					begin
						top_pend <= 1'b0;
						if (pause_pend)
						begin
							state      <= ST_PLAYING;
							pause_pend <= 1'b0;
						end
					end
					ST_GAME_OVER:
					begin
						top_pend <= 1'b0;
						if (new_pend)
						begin
							state    <= ST_NEW_GAME;
							new_pend <= 1'b0;
						end
					end
					default: state <= ST_START;
				endcase
			end
			// Arrivals win over a clear in the same cycle
			if (key_valid && key_code == KEY_PAUSE)
				pause_pend <= 1'b1;
			if (key_valid && key_code == KEY_NEW && state != ST_PLAYING && state != ST_PAUSE)
				new_pend <= 1'b1;
			if (top_out)
				top_pend <= 1'b1;
		end
	end

	assign ctrl = '{state: state, frame_start: frame_start, gravity_tick: gravity_tick};

endmodule

// ==== source/score_keeper.sv ====
module score_keeper
	import tetris_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  game_state_e  state,
	input  line_report_t lines,
	output score_disp_t  disp
);

	logic [VALUE_W-1:0] score_q;
	logic [VALUE_W-1:0] score_next;
	logic [VALUE_W-1:0] line_cnt_q;
	logic [VALUE_W-1:0] line_cnt_next;
	logic [VALUE_W:0]   score_sum;	// One spare bit for the saturation test
	logic [VALUE_W:0]   line_sum;
	logic [VALUE_W-1:0] lvl_div;
	logic [3:0]         points;
	logic [4:0]         level_q;
	logic               count_en;
	logic               score_start;
	logic               lines_start;
	logic               score_busy;
	logic               lines_busy;
	bcd_digit_t [3:0]   score_digits;
	bcd_digit_t [3:0]   line_digits;

	assign count_en  = lines.valid && (state == ST_PLAYING);	// Reports in pause are dropped
	assign points    = (lines.count == 3'd4) ? TETRIS_BONUS : {1'b0, lines.count};
	assign score_sum = score_q + points;
	assign line_sum  = line_cnt_q + lines.count;
	assign lvl_div   = line_cnt_q / LINES_PER_LEVEL;

	always_comb
	begin
		score_next    = score_q;
		line_cnt_next = line_cnt_q;
		if (state == ST_NEW_GAME)
		begin
			score_next    = '0;
			line_cnt_next = '0;
		end
		else if (count_en)
		begin
			score_next    = (score_sum > SCORE_MAX) ? SCORE_MAX : score_sum[VALUE_W-1:0];
			line_cnt_next = (line_sum > SCORE_MAX) ? SCORE_MAX : line_sum[VALUE_W-1:0];	// Same 4-digit limit
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			score_q     <= '0;
			line_cnt_q  <= '0;
			level_q     <= 5'd1;
			score_start <= 1'b0;
			lines_start <= 1'b0;
		end
		else
		begin
			score_q     <= score_next;
			line_cnt_q  <= line_cnt_next;
			score_start <= (score_next != score_q);	// Convert on the next cycle
			lines_start <= (line_cnt_next != line_cnt_q);
			// Level trails the line count by a cycle
			level_q <= (lvl_div >= 14'(LEVEL_MAX - 5'd1)) ? LEVEL_MAX : lvl_div[4:0] + 5'd1;
		end
	end

	bcd_convert score_bcd (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (score_start),
		.value  (score_q),
		.digits (score_digits),
		.busy   (score_busy)
	);

	bcd_convert lines_bcd (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (lines_start),
		.value  (line_cnt_q),
		.digits (line_digits),
		.busy   (lines_busy)
	);

	// Start strobes count as busy too, to close the gap before busy rises
	assign disp = '{
		score_digits: score_digits,
		line_digits:  line_digits,
		level:        level_q,
		digits_valid: ~(score_busy | lines_busy | score_start | lines_start),
		spare:        2'b00
	};

endmodule

// ==== source/tile_writer.sv ====
module tile_writer
	import tetris_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  game_ctrl_t  ctrl,
	input  score_disp_t disp,
	output tile_wr_t    tile_wr
);

	logic       wr_busy;
	logic       wr_over;	// GAMEOVER text instead of numbers
	logic [3:0] step;
	logic [3:0] last_step;
	logic [3:0] score_show;	// Per digit, not a leading zero
	logic [2:0] line_show;
	bcd_digit_t lvl_tens;
	bcd_digit_t lvl_ones;

	function automatic tile_code_t glyph(input bcd_digit_t d, input logic show);
		return show ? tile_code_t'(DIGIT_BASE + d) : BLANK_TILE;
	endfunction

	// Score is drawn times 100, so blanking runs over six digits
	assign score_show[3] = |disp.score_digits[3];
	assign score_show[2] = score_show[3] | (|disp.score_digits[2]);
	assign score_show[1] = score_show[2] | (|disp.score_digits[1]);
	assign score_show[0] = score_show[1] | (|disp.score_digits[0]);
	assign line_show[2]  = |disp.line_digits[3];
	assign line_show[1]  = line_show[2] | (|disp.line_digits[2]);
	assign line_show[0]  = line_show[1] | (|disp.line_digits[1]);

	assign lvl_tens  = (disp.level >= 5'd10) ? 4'd1 : 4'd0;	// Level is at most 16
	assign lvl_ones  = (disp.level >= 5'd10) ? 4'(disp.level - 5'd10) : disp.level[3:0];
	assign last_step = wr_over ? OVER_WRITES - 4'd1 : PLAY_WRITES - 4'd1;

	////////////////////////////////////////////////////////////
	// Step sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_busy <= 1'b0;
			wr_over <= 1'b0;
			step    <= '0;
		end
		else if (ctrl.frame_start)	// Restarts even mid-sequence
		begin
			// Stale digits only matter for the number screen
			wr_busy <= (ctrl.state == ST_GAME_OVER) ||
			           (ctrl.state == ST_PLAYING && disp.digits_valid);
			wr_over <= (ctrl.state == ST_GAME_OVER);
			step    <= '0;
		end
		else if (wr_busy)
		begin
			if (step == last_step)
				wr_busy <= 1'b0;
			else
				step <= step + 4'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Address and glyph per step
	////////////////////////////////////////////////////////////

	always_comb
	begin
		tile_wr.en   = wr_busy;
		tile_wr.addr = '{row: SCORE_ROW, col: SCORE_COL};
		tile_wr.data = BLANK_TILE;
		if (wr_over)
		begin
			// GAME on the first row, OVER below
			tile_wr.addr.row = GAMEOVER_ROW + {4'd0, step[2]};
			tile_wr.addr.col = GAMEOVER_COL + {4'd0, step[1:0]};
			case (step[2:0])
				3'd0: tile_wr.data = GLYPH_G;
				3'd1: tile_wr.data = GLYPH_A;
				3'd2: tile_wr.data = GLYPH_M;
				3'd3: tile_wr.data = GLYPH_E;
				3'd4: tile_wr.data = GLYPH_O;
				3'd5: tile_wr.data = GLYPH_V;
				3'd6: tile_wr.data = GLYPH_E;
				default: tile_wr.data = GLYPH_R;
			endcase
		end
		else if (step <= 4'd5)	// Score, 27 .. 32
		begin
			tile_wr.addr.col = SCORE_COL + {2'b00, step};
			case (step)
				4'd0: tile_wr.data = glyph(disp.score_digits[3], score_show[3]);
				4'd1: tile_wr.data = glyph(disp.score_digits[2], score_show[2]);
				4'd2: tile_wr.data = glyph(disp.score_digits[1], score_show[1]);
				4'd3: tile_wr.data = glyph(disp.score_digits[0], score_show[0]);
				4'd4: tile_wr.data = glyph(4'd0, score_show[0]);
				default: tile_wr.data = glyph(4'd0, 1'b1);	// Last zero always shown
			endcase
		end
		else if (step <= 4'd7)	// Level, 32 .. 33
		begin
			tile_wr.addr.row = LEVEL_ROW;
			tile_wr.addr.col = LEVEL_COL + {5'd0, step[0]};
			tile_wr.data     = step[0] ? glyph(lvl_ones, 1'b1) : glyph(lvl_tens, |lvl_tens);
		end
		else	// Lines, 3 .. 6
		begin
			tile_wr.addr.row = LINES_ROW;
			tile_wr.addr.col = LINES_COL + {4'd0, step[1:0]};
			case (step[1:0])
				2'd0: tile_wr.data = glyph(disp.line_digits[3], line_show[2]);
				2'd1: tile_wr.data = glyph(disp.line_digits[2], line_show[1]);
				2'd2: tile_wr.data = glyph(disp.line_digits[1], line_show[0]);
				default: tile_wr.data = glyph(disp.line_digits[0], 1'b1);
			endcase
		end
	end

endmodule

// ==== source/tetris_supervisor.sv ====
module tetris_supervisor
	import tetris_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         en,	// Frame level from video timing
	input  logic         key_valid,
	input  logic [7:0]   key_code,
	input  line_report_t lines,
	input  logic         top_out,
	output tile_wr_t     tile_wr,
	output logic [4:0]   level,
	output logic         gravity_tick,
	output logic         music_pause,
	output logic         music_game_over
);

	game_ctrl_t  ctrl;
	score_disp_t disp;

	////////////////////////////////////////////////////////////
	// Game control and scoring side by side
	////////////////////////////////////////////////////////////

	game_fsm u_game_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.key_valid (key_valid),
		.key_code  (key_code),
		.top_out   (top_out),
		.level     (disp.level),	// Sets the gravity period
		.ctrl      (ctrl)
	);

	score_keeper u_score_keeper (
		.clk   (clk),
		.rst_n (rst_n),
		.state (ctrl.state),
		.lines (lines),
		.disp  (disp)
	);

	// Screen text from both
	tile_writer u_tile_writer (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ctrl),
		.disp    (disp),
		.tile_wr (tile_wr)
	);

	assign level           = disp.level;
	assign gravity_tick    = ctrl.gravity_tick;
	assign music_pause     = (ctrl.state != ST_PLAYING);	// Music runs only in play
	assign music_game_over = (ctrl.state == ST_GAME_OVER);

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock
(
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held over three rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#10 rst_n = 1'b1;	// Same offset as the stimulus
	end

endmodule

// ==== dv/tb_tetris_supervisor.sv ====
module tb_tetris_supervisor
	import tetris_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES   = 40;
	localparam int EN_HIGH_CYCLES = 2;
	localparam int EVENT_OFFSET   = 20;	// Writer is idle by then
	localparam int TEST_FRAMES    = 88;	// 5 + 6 + 5 + 65 + 7
	localparam int RUN_CYCLES     = 3 + FRAME_CYCLES * TEST_FRAMES;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES * 3 / 2;
	localparam int GRAVITY_FRAMES = 60;

	logic         clk;
	logic         rst_n;
	logic         en;
	logic         key_valid;
	logic [7:0]   key_code;
	line_report_t lines;
	logic         top_out;
	tile_wr_t     tile_wr;
	logic [4:0]   level;
	logic         gravity_tick;
	logic         music_pause;
	logic         music_game_over;

	tile_code_t tile_mem [0:2047];	// Tile memory model
	int         write_count;	// Writes in the current frame
	int         tick_count;
	int         cycle_count;
	int         check_count;
	int         error_count;
	int         exp_score;	// Reference model
	int         exp_lines;
	integer     seed = 32'hd270;

	tb_clock clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	tetris_supervisor dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.en              (en),
		.key_valid       (key_valid),
		.key_code        (key_code),
		.lines           (lines),
		.top_out         (top_out),
		.tile_wr         (tile_wr),
		.level           (level),
		.gravity_tick    (gravity_tick),
		.music_pause     (music_pause),
		.music_game_over (music_game_over)
	);

	// Capture writes and ticks at the edge
	always @(posedge clk)
	begin
		if (tile_wr.en)
		begin
			tile_mem[{tile_wr.addr.row, tile_wr.addr.col}] = tile_wr.data;
			write_count++;
		end
		if (gravity_tick)
			tick_count++;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#10;	// Drive point
	endtask

	// One frame, events pulsed once the writer is done
	task automatic run_frame(input int line_count, input bit send_lines,
			input logic [7:0] key, input bit send_key, input bit send_top);
		write_count = 0;
		en = 1'b1;
		repeat (EN_HIGH_CYCLES) next_cycle();
		en = 1'b0;
		repeat (EVENT_OFFSET - EN_HIGH_CYCLES) next_cycle();
		lines.valid = send_lines;
		lines.count = 3'(line_count);
		key_valid   = send_key;
		key_code    = key;
		top_out     = send_top;
		next_cycle();
		lines     = '0;
		key_valid = 1'b0;
		key_code  = 8'h00;
		top_out   = 1'b0;
		repeat (FRAME_CYCLES - EVENT_OFFSET - 1) next_cycle();
	endtask

	task automatic idle_frame();
		run_frame(0, 1'b0, 8'h00, 1'b0, 1'b0);
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		check_count++;
		assert (got == exp)
		else
		begin
			$display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
			error_count++;
		end
	endtask

	function automatic int tile_index(input int row, input int col);
		return row * 64 + col;	// Row above column
	endfunction

	// Glyph of one position of a right-aligned number, leading zeros blank
	function automatic int number_glyph(input int value, input int width, input int pos);
		int place;
		int digit;
		place = 1;
		for (int i = 0; i < width - 1 - pos; i++)
			place = place * 10;
		digit = (value / place) % 10;
		if (pos == width - 1 || value >= place)
			return DIGIT_BASE + digit;
		return BLANK_TILE;
	endfunction

	task automatic check_number_row(input string label, input int row, input int col0,
			input int value, input int width);
		int col;
		for (int pos = 0; pos < width; pos++)
		begin
			col = col0 + pos;
			check_value($sformatf("%s tile (%0d,%0d)", label, row, col),
				tile_mem[tile_index(row, col)], number_glyph(value, width, pos));
		end
	endtask

	// Bonus for four rows, then the four-digit ceiling
	task automatic apply_report(input int count);
		exp_score += (count == 4) ? TETRIS_BONUS : count;
		if (exp_score > SCORE_MAX)
			exp_score = SCORE_MAX;
		exp_lines += count;
	endtask

	function automatic int expected_level();
		int lvl;
		lvl = exp_lines / int'(LINES_PER_LEVEL) + 1;
		return (lvl > LEVEL_MAX) ? int'(LEVEL_MAX) : lvl;
	endfunction

	task automatic check_display();
		check_number_row("score", SCORE_ROW, SCORE_COL, exp_score * 100, 6);	// Two fixed zeros
		check_number_row("level", LEVEL_ROW, LEVEL_COL, expected_level(), 2);
		check_number_row("lines", LINES_ROW, LINES_COL, exp_lines, 4);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		$display("%s: %s", name, (error_count == errors_before) ? "ok" : "errors found");
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_and_start();
		int errors_before;
		errors_before = error_count;
		for (int f = 0; f < 2; f++)
		begin
			idle_frame();
			check_value("tile_wr writes", write_count, 0);	// Start screen is silent
			check_value("music_pause", music_pause, 1);
			check_value("music_game_over", music_game_over, 0);
		end
		run_frame(0, 1'b0, KEY_NEW, 1'b1, 1'b0);
		idle_frame();	// Start to new game
		idle_frame();	// New game to playing
		check_value("music_pause", music_pause, 0);
		finish_test("reset and start", errors_before);
	endtask

	task automatic pause_toggle();
		int errors_before;
		errors_before = error_count;
		run_frame(0, 1'b0, KEY_PAUSE, 1'b1, 1'b0);
		idle_frame();
		check_value("music_pause", music_pause, 1);
		run_frame(3, 1'b1, 8'h00, 1'b0, 1'b0);	// Dropped while paused
		run_frame(0, 1'b0, KEY_PAUSE, 1'b1, 1'b0);
		idle_frame();
		check_value("music_pause", music_pause, 0);
		idle_frame();	// First frame that writes again
		check_value("tile_wr writes", write_count, 12);
		check_number_row("score", SCORE_ROW, SCORE_COL, exp_score * 100, 6);
		finish_test("pause toggle", errors_before);
	endtask

	task automatic scoring_display();
		int errors_before;
		int count;
		errors_before = error_count;
		for (int f = 0; f < 4; f++)	// At most 16 lines, so level stays below 4
		begin
			count = ($random(seed) & 32'h7fff_ffff) % 5;
			apply_report(count);
			run_frame(count, 1'b1, 8'h00, 1'b0, 1'b0);
		end
		idle_frame();
		check_value("tile_wr writes", write_count, 12);
		check_display();
		finish_test("scoring display", errors_before);
	endtask

	task automatic level_and_gravity();
		int errors_before;
		int expected_ticks;
		errors_before = error_count;
		while (exp_lines < 2 * int'(LINES_PER_LEVEL))
		begin
			apply_report(4);
			run_frame(4, 1'b1, 8'h00, 1'b0, 1'b0);
		end
		idle_frame();
		check_value("level", level, expected_level());
		check_display();
		tick_count = 0;
		repeat (GRAVITY_FRAMES) idle_frame();
		expected_ticks = GRAVITY_FRAMES / (GRAVITY_BASE - expected_level());
		check_count++;
		assert (tick_count >= expected_ticks - 1 && tick_count <= expected_ticks + 1)
		else
		begin
			$display("gravity_tick pulsed %0d times in %0d frames, about %0d were due",
				tick_count, GRAVITY_FRAMES, expected_ticks);
			error_count++;
		end
		finish_test("level and gravity", errors_before);
	endtask

	task automatic game_over_restart();
		int errors_before;
		int row;
		int col;
		int over_glyphs [8];
		errors_before = error_count;
		over_glyphs = '{GLYPH_G, GLYPH_A, GLYPH_M, GLYPH_E, GLYPH_O, GLYPH_V, GLYPH_E, GLYPH_R};
		run_frame(0, 1'b0, 8'h00, 1'b0, 1'b1);	// Top-out
		idle_frame();	// Playing to game over
		check_value("music_game_over", music_game_over, 1);
		idle_frame();
		check_value("tile_wr writes", write_count, 8);
		for (int i = 0; i < 8; i++)
		begin
			row = GAMEOVER_ROW + i / 4;	// GAME, then OVER below
			col = GAMEOVER_COL + i % 4;
			check_value($sformatf("gameover tile (%0d,%0d)", row, col),
				tile_mem[tile_index(row, col)], over_glyphs[i]);
		end
		run_frame(0, 1'b0, KEY_NEW, 1'b1, 1'b0);
		exp_score = 0;
		exp_lines = 0;
		idle_frame();	// Game over to new game
		idle_frame();	// New game to playing
		idle_frame();
		check_value("music_pause", music_pause, 0);
		check_value("music_game_over", music_game_over, 0);
		check_value("tile_wr writes", write_count, 12);
		check_display();
		finish_test("game over and restart", errors_before);
	endtask

	////////////////////////////////////////////////////////////
	// Run
	////////////////////////////////////////////////////////////

	initial
	begin
		en          = 1'b0;
		key_valid   = 1'b0;
		key_code    = 8'h00;
		lines       = '0;
		top_out     = 1'b0;
		write_count = 0;
		tick_count  = 0;
		check_count = 0;
		error_count = 0;
		exp_score   = 0;
		exp_lines   = 0;
		for (int a = 0; a < 2048; a++)
			tile_mem[a] = tile_code_t'(a ^ (a >> 6) ^ 6'h2a);	// Row and column both mixed in
		@(posedge rst_n);	// Released at the drive point
		reset_and_start();
		pause_toggle();
		scoring_display();
		level_and_gravity();
		game_over_restart();
		$display("Tests: 5, checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Cycle limit, half again the length of all tests
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== files.f ====
source/tetris_pkg.sv
source/bcd_convert.sv
source/game_fsm.sv
source/score_keeper.sv
source/tile_writer.sv
source/tetris_supervisor.sv
dv/tb_clock.sv
dv/tb_tetris_supervisor.sv
